//--- hw/rv_id_pkg.sv
package rv_id_pkg;

    // machine word and instruction widths
    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // data and instruction words
    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [ILEN-1:0]       instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // instruction fields
    // opcode is bits 6..2, the low two bits are always 2'b11
    typedef logic [4:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // decode output codes
    typedef logic [4:0] alu_op_t;
    typedef logic [4:0] ext_op_t;
    typedef logic [1:0] src2_sel_t;

    // alu operations, 64-bit forms
    localparam alu_op_t ALU_ADD_64 = 5'd0;
    localparam alu_op_t ALU_SUB_64 = 5'd1;
    localparam alu_op_t ALU_SLL_64 = 5'd2;
    localparam alu_op_t ALU_SRL_64 = 5'd3;
    localparam alu_op_t ALU_SRA_64 = 5'd4;
    // word forms, result sign-extended from bit 31 in execute
    localparam alu_op_t ALU_ADD_32 = 5'd5;
    localparam alu_op_t ALU_SUB_32 = 5'd6;
    localparam alu_op_t ALU_SLL_32 = 5'd7;
    localparam alu_op_t ALU_SRL_32 = 5'd8;
    localparam alu_op_t ALU_SRA_32 = 5'd9;
    // width-independent ops
    localparam alu_op_t ALU_SLT    = 5'd10;
    localparam alu_op_t ALU_SLTU   = 5'd11;
    localparam alu_op_t ALU_XOR    = 5'd12;
    localparam alu_op_t ALU_OR     = 5'd13;
    localparam alu_op_t ALU_AND    = 5'd14;
    // passes operand 2 straight through, lui
    localparam alu_op_t ALU_SRC2   = 5'd15;

    // immediate format, one-hot
    localparam ext_op_t EXT_NONE = 5'b00000;
    localparam ext_op_t EXT_I    = 5'b00001;
    localparam ext_op_t EXT_U    = 5'b00010;
    localparam ext_op_t EXT_S    = 5'b00100;
    localparam ext_op_t EXT_J    = 5'b01000;
    localparam ext_op_t EXT_B    = 5'b10000;

    // operand selects
    localparam logic      SRC1_RS1  = 1'b0;
    localparam logic      SRC1_PC   = 1'b1;
    localparam src2_sel_t SRC2_RS2  = 2'b00;
    localparam src2_sel_t SRC2_IMM  = 2'b01;
    localparam src2_sel_t SRC2_FOUR = 2'b10;

    // opcodes as instr[6:2]
    // bit 1 set marks the 32-bit word variants
    localparam opcode_t OPC_LOAD      = 5'b00000;
    localparam opcode_t OPC_OP_IMM    = 5'b00100;
    localparam opcode_t OPC_AUIPC     = 5'b00101;
    localparam opcode_t OPC_OP_IMM_32 = 5'b00110;
    localparam opcode_t OPC_STORE     = 5'b01000;
    localparam opcode_t OPC_OP        = 5'b01100;
    localparam opcode_t OPC_LUI       = 5'b01101;
    localparam opcode_t OPC_OP_32     = 5'b01110;
    localparam opcode_t OPC_BRANCH    = 5'b11000;
    localparam opcode_t OPC_JALR      = 5'b11001;
    localparam opcode_t OPC_JAL       = 5'b11011;

    // funct3 for the alu groups
    localparam funct3_t F3_ADD_SUB = 3'd0;
    localparam funct3_t F3_SLL     = 3'd1;
    localparam funct3_t F3_SLT     = 3'd2;
    localparam funct3_t F3_SLTU    = 3'd3;
    localparam funct3_t F3_XOR     = 3'd4;
    localparam funct3_t F3_SR      = 3'd5;
    localparam funct3_t F3_OR      = 3'd6;
    localparam funct3_t F3_AND     = 3'd7;

endpackage

//--- hw/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  rv_id_pkg::instr_t    instr_i,
    output rv_id_pkg::ext_op_t   ext_op_o,
    output logic                 src1_sel_o,
    output rv_id_pkg::src2_sel_t src2_sel_o,
    output rv_id_pkg::alu_op_t   alu_op_o,
    output logic                 is_jal_o,
    output logic                 is_jalr_o,
    output logic                 is_brc_o,
    output logic                 wb_en_o
);
    import rv_id_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    is_word;
    logic    is_reg_op;

    // instruction fields
    assign opcode = instr_i[6:2];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // OP-32 and OP-IMM-32 differ from their 64-bit forms only in bit 1
    assign is_word = opcode[1];
    // register-register form, the only one with a sub
    assign is_reg_op = (opcode == OPC_OP) || (opcode == OPC_OP_32);

    // shared funct3 decode for OP and OP-IMM groups
    // alt is funct7 bit 5, selects sub or sra
    function automatic alu_op_t alu_from_f3(
        input funct3_t f3,
        input logic    alt,
        input logic    word,
        input logic    reg_op
    );
        alu_op_t op;
        op = ALU_ADD_64;
        case (f3)
            F3_ADD_SUB: begin
                // addi has no sub form, bit 30 is immediate there
                if (alt && reg_op) begin
                    op = word ? ALU_SUB_32 : ALU_SUB_64;
                end else begin
                    op = word ? ALU_ADD_32 : ALU_ADD_64;
                end
            end
            F3_SLL:  op = word ? ALU_SLL_32 : ALU_SLL_64;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR: begin
                // srai also carries bit 30 in the shamt field
                if (alt) begin
                    op = word ? ALU_SRA_32 : ALU_SRA_64;
                end else begin
                    op = word ? ALU_SRL_32 : ALU_SRL_64;
                end
            end
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD_64;
        endcase
        return op;
    endfunction

    always_comb begin
        // defaults, also the unknown opcode result
        ext_op_o   = EXT_NONE;
        alu_op_o   = ALU_ADD_64;
        src1_sel_o = SRC1_RS1;
        src2_sel_o = SRC2_RS2;
        is_jal_o   = 1'b0;
        is_jalr_o  = 1'b0;
        is_brc_o   = 1'b0;
        wb_en_o    = 1'b0;

        case (opcode)
            OPC_OP, OPC_OP_32: begin
                // rs1 op rs2
                alu_op_o = alu_from_f3(funct3, funct7[5], is_word, is_reg_op);
                wb_en_o  = 1'b1;
            end
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                // rs1 op imm
                alu_op_o   = alu_from_f3(funct3, funct7[5], is_word, is_reg_op);
                ext_op_o   = EXT_I;
                src2_sel_o = SRC2_IMM;
                wb_en_o    = 1'b1;
            end
            OPC_LOAD: begin
                // address is rs1 + imm
                ext_op_o   = EXT_I;
                src2_sel_o = SRC2_IMM;
                wb_en_o    = 1'b1;
            end
            OPC_STORE: begin
                // same address calc, nothing written back
                ext_op_o   = EXT_S;
                src2_sel_o = SRC2_IMM;
            end
            OPC_BRANCH: begin
                // compare happens outside, target uses B imm
                ext_op_o = EXT_B;
                is_brc_o = 1'b1;
            end
            OPC_JAL: begin
                // rd gets pc + 4
                ext_op_o   = EXT_J;
                src1_sel_o = SRC1_PC;
                src2_sel_o = SRC2_FOUR;
                is_jal_o   = 1'b1;
                wb_en_o    = 1'b1;
            end
            OPC_JALR: begin
                // rd gets pc + 4, target is rs1 + I imm
                ext_op_o   = EXT_I;
                src1_sel_o = SRC1_PC;
                src2_sel_o = SRC2_FOUR;
                is_jalr_o  = 1'b1;
                wb_en_o    = 1'b1;
            end
            OPC_LUI: begin
                // result is the U imm itself
                ext_op_o   = EXT_U;
                src2_sel_o = SRC2_IMM;
                alu_op_o   = ALU_SRC2;
                wb_en_o    = 1'b1;
            end
            OPC_AUIPC: begin
                // pc + U imm
                ext_op_o   = EXT_U;
                src1_sel_o = SRC1_PC;
                src2_sel_o = SRC2_IMM;
                wb_en_o    = 1'b1;
            end
            default: begin
                // keep defaults
                wb_en_o = 1'b0;
            end
        endcase
    end

endmodule

//--- hw/rv_imm_ext.sv
`timescale 1ns/1ps

module rv_imm_ext (
    input  logic [31:7]        instr_imm_i,
    input  rv_id_pkg::ext_op_t ext_op_i,
    output rv_id_pkg::xlen_t   imm_o
);
    import rv_id_pkg::*;

    logic sgn;

    // every format takes its sign from instr[31]
    assign sgn = instr_imm_i[31];

    always_comb begin
        case (ext_op_i)
            EXT_I: begin
                // imm[11:0]
                imm_o = {{(XLEN-12){sgn}}, instr_imm_i[31:20]};
            end
            EXT_S: begin
                // imm[11:5] from funct7 slot, imm[4:0] from rd slot
                imm_o = {{(XLEN-12){sgn}}, instr_imm_i[31:25], instr_imm_i[11:7]};
            end
            EXT_B: begin
                // imm[12] is the sign, imm[11] sits in bit 7
                imm_o = {{(XLEN-12){sgn}}, instr_imm_i[7], instr_imm_i[30:25],
                         instr_imm_i[11:8], 1'b0};
            end
            EXT_U: begin
                // upper 20 bits, low 12 cleared
                imm_o = {{(XLEN-32){sgn}}, instr_imm_i[31:12], 12'h000};
            end
            EXT_J: begin
                // imm[20] sign, then [19:12], [11], [10:1]
                imm_o = {{(XLEN-20){sgn}}, instr_imm_i[19:12], instr_imm_i[20],
                         instr_imm_i[30:21], 1'b0};
            end
            default: begin
                // EXT_NONE and any non one-hot code
                imm_o = '0;
            end
        endcase
    end

endmodule

//--- hw/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  rv_id_pkg::reg_addr_t rs1_addr_i,
    input  rv_id_pkg::reg_addr_t rs2_addr_i,
    input  rv_id_pkg::reg_addr_t wr_addr_i,
    input  rv_id_pkg::xlen_t     wr_data_i,
    input  logic                 wr_en_i,
    output rv_id_pkg::xlen_t     rs1_data_o,
    output rv_id_pkg::xlen_t     rs2_data_o
);
    import rv_id_pkg::*;

    // storage for x1..x31 only
    xlen_t                regs [1:NUM_REGS-1];
    logic [NUM_REGS-1:0]  wr_sel;

    // one-hot write select that never picks x0
    always_comb begin
        wr_sel = '0;
        if (wr_en_i && (wr_addr_i != '0)) begin
            wr_sel[wr_addr_i] = 1'b1;
        end
    end

    // x1..x31
    for (genvar i = 1; i < NUM_REGS; i++) begin : g_reg
        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                regs[i] <= '0;
            end else if (wr_sel[i]) begin
                regs[i] <= wr_data_i;
            end
        end
    end

    // async reads with x0 forced to zero
    // a same-cycle write shows up next cycle only
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- hw/rv_id_stage.sv
`timescale 1ns/1ps

module rv_id_stage (
    input  logic                 clk,
    input  logic                 arst_n_i,
    // from fetch
    input  rv_id_pkg::xlen_t     pc_i,
    input  rv_id_pkg::instr_t    instr_i,
    // from writeback
    input  rv_id_pkg::reg_addr_t wb_rd_i,
    input  rv_id_pkg::xlen_t     wb_data_i,
    input  logic                 wb_we_i,
    // operands
    output rv_id_pkg::xlen_t     rs1_data_o,
    output rv_id_pkg::xlen_t     rs2_data_o,
    output rv_id_pkg::xlen_t     imm_o,
    // execute controls
    output logic                 src1_sel_o,
    output rv_id_pkg::src2_sel_t src2_sel_o,
    output rv_id_pkg::alu_op_t   alu_op_o,
    output logic                 is_jal_o,
    output logic                 is_jalr_o,
    output logic                 is_brc_o,
    output logic                 wb_en_o
);
    import rv_id_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    ext_op_t   ext_op;

    // source register fields
    assign rs1_addr = instr_i[19:15];
    assign rs2_addr = instr_i[24:20];

    // pc_i travels with the instruction, operand muxing is in execute

    rv_decoder u_decoder (
        .instr_i    (instr_i),
        .ext_op_o   (ext_op),
        .src1_sel_o (src1_sel_o),
        .src2_sel_o (src2_sel_o),
        .alu_op_o   (alu_op_o),
        .is_jal_o   (is_jal_o),
        .is_jalr_o  (is_jalr_o),
        .is_brc_o   (is_brc_o),
        .wb_en_o    (wb_en_o)
    );

    // opcode bits never feed the immediate
    rv_imm_ext u_imm_ext (
        .instr_imm_i (instr_i[31:7]),
        .ext_op_i    (ext_op),
        .imm_o       (imm_o)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wr_addr_i  (wb_rd_i),
        .wr_data_i  (wb_data_i),
        .wr_en_i    (wb_we_i),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

endmodule

//--- bench/rv_id_stage_props.sv
`timescale 1ns/1ps

module rv_id_stage_props (
    input logic                 clk,
    input logic                 arst_n_i,
    input rv_id_pkg::instr_t    instr_i,
    input rv_id_pkg::reg_addr_t wb_rd_i,
    input rv_id_pkg::xlen_t     wb_data_i,
    input logic                 wb_we_i,
    input rv_id_pkg::xlen_t     rs1_data_o,
    input rv_id_pkg::xlen_t     rs2_data_o,
    input logic                 is_jal_o,
    input logic                 is_jalr_o,
    input logic                 is_brc_o,
    input logic                 wb_en_o
);
    import rv_id_pkg::*;

    // x0 reads zero on both ports
    a_rs1_x0: assert property (@(posedge clk) disable iff (!arst_n_i)
        (instr_i[19:15] == '0) |-> (rs1_data_o == '0))
        else $error("rs1 port read nonzero from x0");
    a_rs2_x0: assert property (@(posedge clk) disable iff (!arst_n_i)
        (instr_i[24:20] == '0) |-> (rs2_data_o == '0))
        else $error("rs2 port read nonzero from x0");

    // jump and branch flags exclusive
    a_flags: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0({is_jal_o, is_jalr_o, is_brc_o}))
        else $error("more than one control flow flag high");

    a_brc_no_wb: assert property (@(posedge clk) disable iff (!arst_n_i)
        is_brc_o |-> !wb_en_o)
        else $error("branch with writeback enabled");

    // written value seen next cycle on a port addressed to it
    a_wr_visible: assert property (@(posedge clk) disable iff (!arst_n_i)
        (wb_we_i && wb_rd_i != '0) |=>
            ((instr_i[19:15] != $past(wb_rd_i)) || (rs1_data_o == $past(wb_data_i))) &&
            ((instr_i[24:20] != $past(wb_rd_i)) || (rs2_data_o == $past(wb_data_i))))
        else $error("register write not visible one cycle later");

endmodule

bind rv_id_stage rv_id_stage_props u_props (.*);

//--- bench/tb_rv_id_stage.sv
`timescale 1ns/1ps

module tb_rv_id_stage;
    import rv_id_pkg::*;

    localparam int unsigned MAX_CYCLES = 2000;

    logic      clk;
    logic      arst_n_i;
    xlen_t     pc_i;
    instr_t    instr_i;
    reg_addr_t wb_rd_i;
    xlen_t     wb_data_i;
    logic      wb_we_i;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     imm;
    logic      src1_sel;
    src2_sel_t src2_sel;
    alu_op_t   alu_op;
    logic      is_jal;
    logic      is_jalr;
    logic      is_brc;
    logic      wb_en;

    // expected register contents
    xlen_t       shadow [32];
    int unsigned cycles;

    rv_id_stage DUT (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .pc_i       (pc_i),
        .instr_i    (instr_i),
        .wb_rd_i    (wb_rd_i),
        .wb_data_i  (wb_data_i),
        .wb_we_i    (wb_we_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .imm_o      (imm),
        .src1_sel_o (src1_sel),
        .src2_sel_o (src2_sel),
        .alu_op_o   (alu_op),
        .is_jal_o   (is_jal),
        .is_jalr_o  (is_jalr),
        .is_brc_o   (is_brc),
        .wb_en_o    (wb_en)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run();
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    // run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            fail_run();
        end
    end

    task automatic check_xlen(string name, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_alu_op(string name, alu_op_t got, alu_op_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_src2(string name, src2_sel_t got, src2_sel_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    // expected alu op from funct3, alt bit and word form
    function automatic alu_op_t expect_alu(logic word, logic reg_form, funct3_t f3, logic alt);
        alu_op_t base [8] = '{ALU_ADD_64, ALU_SLL_64, ALU_SLT, ALU_SLTU,
                              ALU_XOR, ALU_SRL_64, ALU_OR, ALU_AND};
        alu_op_t op;
        op = base[f3];
        // sub only in the register form
        if (f3 == F3_ADD_SUB && alt && reg_form)
            op = ALU_SUB_64;
        if (f3 == F3_SR && alt)
            op = ALU_SRA_64;
        if (word) begin
            case (op)
                ALU_ADD_64: op = ALU_ADD_32;
                ALU_SUB_64: op = ALU_SUB_32;
                ALU_SLL_64: op = ALU_SLL_32;
                ALU_SRL_64: op = ALU_SRL_32;
                ALU_SRA_64: op = ALU_SRA_32;
                default:    op = op;
            endcase
        end
        return op;
    endfunction

    // reference immediate, format picked by opcode
    function automatic xlen_t expect_imm(instr_t w);
        logic [11:0] i_imm;
        logic [11:0] s_imm;
        logic [12:0] b_imm;
        logic [31:0] u_imm;
        logic [20:0] j_imm;
        i_imm = w[31:20];
        s_imm = {w[31:25], w[11:7]};
        b_imm = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        u_imm = {w[31:12], 12'h000};
        j_imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        case (opcode_t'(w[6:2]))
            OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32, OPC_JALR: return xlen_t'($signed(i_imm));
            OPC_STORE:                                     return xlen_t'($signed(s_imm));
            OPC_BRANCH:                                    return xlen_t'($signed(b_imm));
            OPC_LUI, OPC_AUIPC:                            return xlen_t'($signed(u_imm));
            OPC_JAL:                                       return xlen_t'($signed(j_imm));
            default:                                       return '0;
        endcase
    endfunction

    function automatic instr_t rand_instr(opcode_t opc);
        instr_t w;
        w = $urandom;
        w[6:0] = {opc, 2'b11};
        return w;
    endfunction

    // drive after the edge, let decode settle
    task automatic apply_instr(instr_t w);
        @(posedge clk);
        #1;
        instr_i = w;
        #1;
    endtask

    task automatic check_controls(logic e_src1, src2_sel_t e_src2, alu_op_t e_alu,
                                  logic e_jal, logic e_jalr, logic e_brc, logic e_wb);
        check_bit("src1_sel_o", src1_sel, e_src1);
        check_src2("src2_sel_o", src2_sel, e_src2);
        check_alu_op("alu_op_o", alu_op, e_alu);
        check_bit("is_jal_o", is_jal, e_jal);
        check_bit("is_jalr_o", is_jalr, e_jalr);
        check_bit("is_brc_o", is_brc, e_brc);
        check_bit("wb_en_o", wb_en, e_wb);
    endtask

    task automatic test_regfile();
        xlen_t data;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
            apply_instr({7'b0, 5'(r), 5'(r), 3'b0, 5'b0, OPC_OP, 2'b11});
            check_xlen("rs1_data_o", rs1_data, '0);
            check_xlen("rs2_data_o", rs2_data, '0);
        end
        // write r while reading r (old) and r-1 (written last cycle)
        for (int r = 1; r < 32; r++) begin
            data = {$urandom, $urandom};
            @(posedge clk);
            #1;
            wb_we_i   = 1'b1;
            wb_rd_i   = 5'(r);
            wb_data_i = data;
            instr_i   = {7'b0, 5'(r - 1), 5'(r), 3'b0, 5'b0, OPC_OP, 2'b11};
            #1;
            check_xlen("rs1_data_o", rs1_data, shadow[r]);
            check_xlen("rs2_data_o", rs2_data, shadow[r - 1]);
            shadow[r] = data;
        end
        // x0 write is dropped
        @(posedge clk);
        #1;
        wb_rd_i   = '0;
        wb_data_i = {$urandom, $urandom};
        apply_instr({7'b0, 5'd0, 5'd0, 3'b0, 5'b0, OPC_OP, 2'b11});
        wb_we_i = 1'b0;
        check_xlen("rs1_data_o", rs1_data, '0);
        check_xlen("rs2_data_o", rs2_data, '0);
        for (int r = 1; r < 32; r++) begin
            apply_instr({7'b0, 5'(32 - r), 5'(r), 3'b0, 5'b0, OPC_OP, 2'b11});
            check_xlen("rs1_data_o", rs1_data, shadow[r]);
            check_xlen("rs2_data_o", rs2_data, shadow[32 - r]);
        end
    endtask

    task automatic test_reg_alu();
        opcode_t   ops [2] = '{OPC_OP, OPC_OP_32};
        reg_addr_t rs1;
        reg_addr_t rs2;
        for (int i = 0; i < 2; i++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    rs1 = 5'($urandom);
                    rs2 = 5'($urandom);
                    apply_instr({1'b0, 1'(alt), 5'b0, rs2, rs1, 3'(f3), 5'd1, ops[i], 2'b11});
                    check_controls(SRC1_RS1, SRC2_RS2, expect_alu(i == 1, 1'b1, 3'(f3), 1'(alt)),
                                   1'b0, 1'b0, 1'b0, 1'b1);
                    check_xlen("rs1_data_o", rs1_data, shadow[rs1]);
                    check_xlen("rs2_data_o", rs2_data, shadow[rs2]);
                end
            end
        end
    endtask

    task automatic test_imm_alu();
        opcode_t ops [2] = '{OPC_OP_IMM, OPC_OP_IMM_32};
        instr_t  w;
        for (int i = 0; i < 2; i++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                repeat (4) begin
                    w = rand_instr(ops[i]);
                    w[14:12] = 3'(f3);
                    apply_instr(w);
                    check_controls(SRC1_RS1, SRC2_IMM, expect_alu(i == 1, 1'b0, 3'(f3), w[30]),
                                   1'b0, 1'b0, 1'b0, 1'b1);
                    check_xlen("imm_o", imm, expect_imm(w));
                end
            end
        end
    endtask

    task automatic test_imm_formats();
        opcode_t ops [6] = '{OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_LUI, OPC_AUIPC, OPC_JAL};
        for (int i = 0; i < 6; i++) begin
            repeat (8) begin
                apply_instr(rand_instr(ops[i]));
                check_xlen("imm_o", imm, expect_imm(instr_i));
            end
        end
    endtask

    task automatic test_control();
        apply_instr(rand_instr(OPC_JAL));
        check_controls(SRC1_PC, SRC2_FOUR, ALU_ADD_64, 1'b1, 1'b0, 1'b0, 1'b1);
        apply_instr(rand_instr(OPC_JALR));
        check_controls(SRC1_PC, SRC2_FOUR, ALU_ADD_64, 1'b0, 1'b1, 1'b0, 1'b1);
        check_xlen("imm_o", imm, expect_imm(instr_i));
        apply_instr(rand_instr(OPC_BRANCH));
        check_controls(SRC1_RS1, SRC2_RS2, ALU_ADD_64, 1'b0, 1'b0, 1'b1, 1'b0);
        apply_instr(rand_instr(OPC_STORE));
        check_controls(SRC1_RS1, SRC2_IMM, ALU_ADD_64, 1'b0, 1'b0, 1'b0, 1'b0);
        apply_instr(rand_instr(OPC_LOAD));
        check_controls(SRC1_RS1, SRC2_IMM, ALU_ADD_64, 1'b0, 1'b0, 1'b0, 1'b1);
        apply_instr(rand_instr(OPC_LUI));
        check_controls(SRC1_RS1, SRC2_IMM, ALU_SRC2, 1'b0, 1'b0, 1'b0, 1'b1);
        apply_instr(rand_instr(OPC_AUIPC));
        check_controls(SRC1_PC, SRC2_IMM, ALU_ADD_64, 1'b0, 1'b0, 1'b0, 1'b1);
    endtask

    task automatic test_unknown();
        // misc-mem, load-fp, op-fp, system
        opcode_t ops [4] = '{5'b00011, 5'b00001, 5'b10100, 5'b11100};
        for (int i = 0; i < 4; i++) begin
            apply_instr(rand_instr(ops[i]));
            check_controls(SRC1_RS1, SRC2_RS2, ALU_ADD_64, 1'b0, 1'b0, 1'b0, 1'b0);
            check_xlen("imm_o", imm, '0);
        end
    endtask

    initial begin
        void'($urandom(32'h6fee088d));
        cycles    = 0;
        arst_n_i  = 1'b0;
        pc_i      = 64'h0000_0000_8000_0000;
        instr_i   = '0;
        wb_rd_i   = '0;
        wb_data_i = '0;
        wb_we_i   = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arst_n_i = 1'b1;

        test_regfile();
        test_reg_alu();
        test_imm_alu();
        test_imm_formats();
        test_control();
        test_unknown();

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- compile.f
hw/rv_id_pkg.sv
hw/rv_decoder.sv
hw/rv_imm_ext.sv
hw/rv_regfile.sv
hw/rv_id_stage.sv
bench/rv_id_stage_props.sv
bench/tb_rv_id_stage.sv
